/* design/rv_exec_consts.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Width constants of the RV64I execute stage
// Register, word and shift-amount field widths
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

// Register and address width
`define XLEN 64
`define REGNO_W 5

// Shift amounts for doubleword and word shifts
`define SHAMT_W 6
`define SHAMTW_W 5

`define WORD_W 32

`endif

/* design/rv_exec_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage types
// Opcode enum and load-use stall state enum
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package rv_exec_pkg;

    // Dropped instructions decode to op_nop
    typedef enum logic [5:0]
    {
        op_nop,
        op_sb, op_sh, op_sw, op_sd,
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_jal, op_jalr,
        op_lui, op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and,
        op_addiw, op_slliw, op_srliw, op_sraiw,
        op_addw, op_subw, op_sllw, op_srlw, op_sraw
    } opcode_t;

    typedef enum logic
    {
        st_run,
        st_load_wait
    } stall_state_t;

endpackage

`default_nettype wire

/* design/operand_forward.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand forwarding for rs1 and rs2
// Load-use hazard detection
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_consts.svh"

module operand_forward
(
    input  logic [`XLEN-1:0]    rs1_value,
    input  logic [`XLEN-1:0]    rs2_value,
    input  logic [`REGNO_W-1:0] rs1_regno,
    input  logic [`REGNO_W-1:0] rs2_regno,
    input  logic [`REGNO_W-1:0] alu_rd_regno,
    input  logic [`XLEN-1:0]    alu_result_fwd,
    input  logic                alu_is_load,
    input  logic [`REGNO_W-1:0] mm_rd_regno,
    input  logic [`XLEN-1:0]    mm_alu_result,
    input  logic [`XLEN-1:0]    mm_data,
    input  logic                mm_is_load,
    input  logic [`REGNO_W-1:0] wb_rd_regno,
    input  logic [`XLEN-1:0]    wb_data,
    input  logic                load_wait,
    output logic [`XLEN-1:0]    op_a,
    output logic [`XLEN-1:0]    op_b,
    output logic                load_hazard
);
    logic [`REGNO_W-1:0] src_regno [2];
    logic [`XLEN-1:0]    rf_value [2];
    logic [`XLEN-1:0]    fwd_value [2];
    logic [1:0]          src_hazard;

    assign src_regno[0] = rs1_regno;
    assign src_regno[1] = rs2_regno;
    assign rf_value[0]  = rs1_value;
    assign rf_value[1]  = rs2_value;

    // Youngest producer wins: ALU stage, then memory, then writeback
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            src_hazard[i] = 1'b0;
            if (src_regno[i] == alu_rd_regno && alu_is_load)
            begin
                src_hazard[i] = 1'b1;
                // Load data has reached the memory stage by the wait cycle
                fwd_value[i] = load_wait ? mm_data : alu_result_fwd;
            end
            else if (src_regno[i] == alu_rd_regno)
                fwd_value[i] = alu_result_fwd;
            else if (src_regno[i] == mm_rd_regno)
                fwd_value[i] = mm_is_load ? mm_data : mm_alu_result;
            else if (src_regno[i] == wb_rd_regno)
                fwd_value[i] = wb_data;
            else
                fwd_value[i] = rf_value[i];
        end
    end

    assign op_a        = fwd_value[0];
    assign op_b        = fwd_value[1];
    assign load_hazard = |src_hazard;

endmodule

`default_nettype wire

/* design/load_use_fsm.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load-use stall FSM
// Drives ready and the wait-state flag
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module load_use_fsm
(
    input  logic clk,
    input  logic reset,
    input  logic in_enable,
    input  logic load_hazard,
    input  logic flush,
    output logic ready,
    output logic load_wait
);
    import rv_exec_pkg::*;

    stall_state_t state;
    stall_state_t state_next;

    // A hazard instruction is refused once, then taken in the wait state
    assign ready     = !(load_hazard && state == st_run);
    assign load_wait = (state == st_load_wait);

    always_comb
    begin
        state_next = state;
        if (in_enable && ready && flush)
            state_next = st_run;
        else if (in_enable)
        begin
            case (state)
                st_run:
                    if (load_hazard)
                        state_next = st_load_wait;
                st_load_wait:
                    state_next = st_run;
                default:
                    state_next = st_run;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= st_run;
        else
            state <= state_next;
    end

endmodule

`default_nettype wire

/* design/int_alu.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer ALU for RV64I
// Arithmetic, shifts, compares, word forms,
// memory address and link value
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_consts.svh"

module int_alu
(
    input  rv_exec_pkg::opcode_t opcode,
    input  logic [`XLEN-1:0]     op_a,
    input  logic [`XLEN-1:0]     op_b,
    input  logic [`XLEN-1:0]     imm,
    input  logic [`XLEN-1:0]     pc,
    output logic [`XLEN-1:0]     alu_result,
    output logic                 update_rd,
    output logic                 mm_load
);
    import rv_exec_pkg::*;

    logic [`SHAMT_W-1:0]  shamt_reg;
    logic [`SHAMT_W-1:0]  shamt_imm;
    logic [`SHAMTW_W-1:0] shamtw_reg;
    logic [`SHAMTW_W-1:0] shamtw_imm;
    logic [`XLEN-1:0]     mem_addr;

    function automatic logic [`XLEN-1:0] sext_word(input logic [`WORD_W-1:0] word);
        return {{(`XLEN-`WORD_W){word[`WORD_W-1]}}, word};
    endfunction

    function automatic logic [`XLEN-1:0] flag(input logic bit_value);
        return {{(`XLEN-1){1'b0}}, bit_value};
    endfunction

    assign shamt_reg  = op_b[`SHAMT_W-1:0];
    assign shamt_imm  = imm[`SHAMT_W-1:0];
    assign shamtw_reg = op_b[`SHAMTW_W-1:0];
    assign shamtw_imm = imm[`SHAMTW_W-1:0];
    assign mem_addr   = op_a + imm;

    always_comb
    begin
        alu_result = '0;
        case (opcode)
            op_sb, op_sh, op_sw, op_sd,
            op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu: alu_result = mem_addr;
            op_jal, op_jalr: alu_result = pc + `XLEN'd4;
            op_lui:   alu_result = imm;
            op_addi:  alu_result = op_a + imm;
            op_slti:  alu_result = flag($signed(op_a) < $signed(imm));
            op_sltiu: alu_result = flag(op_a < imm);
            op_xori:  alu_result = op_a ^ imm;
            op_ori:   alu_result = op_a | imm;
            op_andi:  alu_result = op_a & imm;
            op_slli:  alu_result = op_a << shamt_imm;
            op_srli:  alu_result = op_a >> shamt_imm;
            op_srai:  alu_result = $signed(op_a) >>> shamt_imm;
            op_add:   alu_result = op_a + op_b;
            op_sub:   alu_result = op_a - op_b;
            op_sll:   alu_result = op_a << shamt_reg;
            op_slt:   alu_result = flag($signed(op_a) < $signed(op_b));
            op_sltu:  alu_result = flag(op_a < op_b);
            op_xor:   alu_result = op_a ^ op_b;
            op_srl:   alu_result = op_a >> shamt_reg;
            op_sra:   alu_result = $signed(op_a) >>> shamt_reg;
            op_or:    alu_result = op_a | op_b;
            op_and:   alu_result = op_a & op_b;
            // Word forms work on the low 32 bits, then sign-extend bit 31
            op_addiw: alu_result = sext_word(op_a[`WORD_W-1:0] + imm[`WORD_W-1:0]);
            op_slliw: alu_result = sext_word(op_a[`WORD_W-1:0] << shamtw_imm);
            op_srliw: alu_result = sext_word(op_a[`WORD_W-1:0] >> shamtw_imm);
            op_sraiw: alu_result = sext_word($signed(op_a[`WORD_W-1:0]) >>> shamtw_imm);
            op_addw:  alu_result = sext_word(op_a[`WORD_W-1:0] + op_b[`WORD_W-1:0]);
            op_subw:  alu_result = sext_word(op_a[`WORD_W-1:0] - op_b[`WORD_W-1:0]);
            op_sllw:  alu_result = sext_word(op_a[`WORD_W-1:0] << shamtw_reg);
            op_srlw:  alu_result = sext_word(op_a[`WORD_W-1:0] >> shamtw_reg);
            op_sraw:  alu_result = sext_word($signed(op_a[`WORD_W-1:0]) >>> shamtw_reg);
            default:  alu_result = '0;
        endcase
    end

    always_comb
    begin
        update_rd = 1'b0;
        mm_load   = 1'b0;
        case (opcode)
            op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu:
                mm_load = 1'b1;
            op_jal, op_jalr, op_lui,
            op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
            op_slli, op_srli, op_srai,
            op_add, op_sub, op_sll, op_slt, op_sltu,
            op_xor, op_srl, op_sra, op_or, op_and,
            op_addiw, op_slliw, op_srliw, op_sraiw,
            op_addw, op_subw, op_sllw, op_srlw, op_sraw:
                update_rd = 1'b1;
            default:
                update_rd = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* design/branch_resolve.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch and jump resolution
// Taken flag and next program counter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_consts.svh"

module branch_resolve
(
    input  rv_exec_pkg::opcode_t opcode,
    input  logic [`XLEN-1:0]     op_a,
    input  logic [`XLEN-1:0]     op_b,
    input  logic [`XLEN-1:0]     imm,
    input  logic [`XLEN-1:0]     pc,
    output logic                 branch_taken,
    output logic [`XLEN-1:0]     next_pc
);
    import rv_exec_pkg::*;

    logic [`XLEN-1:0] jalr_target;

    assign jalr_target = op_a + imm;

    always_comb
    begin
        case (opcode)
            op_beq:  branch_taken = (op_a == op_b);
            op_bne:  branch_taken = (op_a != op_b);
            op_blt:  branch_taken = ($signed(op_a) < $signed(op_b));
            op_bge:  branch_taken = ($signed(op_a) >= $signed(op_b));
            op_bltu: branch_taken = (op_a < op_b);
            op_bgeu: branch_taken = (op_a >= op_b);
            op_jal, op_jalr: branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

    // jalr target has bit 0 forced low
    always_comb
    begin
        if (opcode == op_jalr)
            next_pc = {jalr_target[`XLEN-1:1], 1'b0};
        else if (branch_taken)
            next_pc = pc + imm;
        else
            next_pc = pc + `XLEN'd4;
    end

endmodule

`default_nettype wire

/* design/ex_mm_latch.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute-to-memory pipeline register
// Loads a bubble on flush or reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_consts.svh"

module ex_mm_latch
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 accept,
    input  logic                 flush,
    input  logic [`XLEN-1:0]     ex_result,
    input  logic                 ex_update_rd,
    input  logic                 ex_mm_load,
    input  logic                 ex_branch_taken,
    input  logic [`XLEN-1:0]     ex_next_pc,
    input  logic [`XLEN-1:0]     op_b,
    input  logic [`REGNO_W-1:0]  rd_regno,
    input  rv_exec_pkg::opcode_t opcode,
    output logic [`XLEN-1:0]     alu_result,
    output logic [`XLEN-1:0]     store_data,
    output logic [`XLEN-1:0]     next_pc,
    output logic [`REGNO_W-1:0]  rd_out,
    output rv_exec_pkg::opcode_t opcode_out,
    output logic                 update_rd_out,
    output logic                 branch_taken_out,
    output logic                 mm_load_out
);
    import rv_exec_pkg::*;

    always_ff @(posedge clk)
    begin
        if (reset || (accept && flush))
        begin
            alu_result       <= '0;
            store_data       <= '0;
            next_pc          <= '0;
            rd_out           <= '0;
            opcode_out       <= op_nop;
            update_rd_out    <= 1'b0;
            branch_taken_out <= 1'b0;
            mm_load_out      <= 1'b0;
        end
        else if (accept)
        begin
            alu_result       <= ex_result;
            store_data       <= op_b;
            next_pc          <= ex_next_pc;
            rd_out           <= rd_regno;
            opcode_out       <= opcode;
            update_rd_out    <= ex_update_rd;
            branch_taken_out <= ex_branch_taken;
            mm_load_out      <= ex_mm_load;
        end
    end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV64I execute stage top level
// Forwarding, stall FSM, ALU, branch unit
// and the execute-to-memory register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_consts.svh"

module execute_stage
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_enable,
    input  logic                 flush,
    input  rv_exec_pkg::opcode_t opcode,
    input  logic [`XLEN-1:0]     pc,
    input  logic [`XLEN-1:0]     imm,
    input  logic [`XLEN-1:0]     rs1_value,
    input  logic [`XLEN-1:0]     rs2_value,
    input  logic [`REGNO_W-1:0]  rs1_regno,
    input  logic [`REGNO_W-1:0]  rs2_regno,
    input  logic [`REGNO_W-1:0]  rd_regno,
    input  logic [`REGNO_W-1:0]  alu_rd_regno,
    input  logic [`XLEN-1:0]     alu_result_fwd,
    input  logic                 alu_is_load,
    input  logic [`REGNO_W-1:0]  mm_rd_regno,
    input  logic [`XLEN-1:0]     mm_alu_result,
    input  logic [`XLEN-1:0]     mm_data,
    input  logic                 mm_is_load,
    input  logic [`REGNO_W-1:0]  wb_rd_regno,
    input  logic [`XLEN-1:0]     wb_data,
    output logic                 ready,
    output logic [`XLEN-1:0]     alu_result,
    output logic [`XLEN-1:0]     store_data,
    output logic [`XLEN-1:0]     next_pc,
    output logic [`REGNO_W-1:0]  rd_out,
    output rv_exec_pkg::opcode_t opcode_out,
    output logic                 update_rd_out,
    output logic                 branch_taken_out,
    output logic                 mm_load_out
);
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic             load_hazard;
    logic             load_wait;
    logic             accept;
    logic [`XLEN-1:0] ex_result;
    logic             ex_update_rd;
    logic             ex_mm_load;
    logic             ex_branch_taken;
    logic [`XLEN-1:0] ex_next_pc;

    assign accept = in_enable && ready;

    operand_forward i_forward
    (
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .rs1_regno      (rs1_regno),
        .rs2_regno      (rs2_regno),
        .alu_rd_regno   (alu_rd_regno),
        .alu_result_fwd (alu_result_fwd),
        .alu_is_load    (alu_is_load),
        .mm_rd_regno    (mm_rd_regno),
        .mm_alu_result  (mm_alu_result),
        .mm_data        (mm_data),
        .mm_is_load     (mm_is_load),
        .wb_rd_regno    (wb_rd_regno),
        .wb_data        (wb_data),
        .load_wait      (load_wait),
        .op_a           (op_a),
        .op_b           (op_b),
        .load_hazard    (load_hazard)
    );

    load_use_fsm i_stall
    (
        .clk         (clk),
        .reset       (reset),
        .in_enable   (in_enable),
        .load_hazard (load_hazard),
        .flush       (flush),
        .ready       (ready),
        .load_wait   (load_wait)
    );

    int_alu i_alu
    (
        .opcode     (opcode),
        .op_a       (op_a),
        .op_b       (op_b),
        .imm        (imm),
        .pc         (pc),
        .alu_result (ex_result),
        .update_rd  (ex_update_rd),
        .mm_load    (ex_mm_load)
    );

    branch_resolve i_branch
    (
        .opcode       (opcode),
        .op_a         (op_a),
        .op_b         (op_b),
        .imm          (imm),
        .pc           (pc),
        .branch_taken (ex_branch_taken),
        .next_pc      (ex_next_pc)
    );

    ex_mm_latch i_latch
    (
        .clk              (clk),
        .reset            (reset),
        .accept           (accept),
        .flush            (flush),
        .ex_result        (ex_result),
        .ex_update_rd     (ex_update_rd),
        .ex_mm_load       (ex_mm_load),
        .ex_branch_taken  (ex_branch_taken),
        .ex_next_pc       (ex_next_pc),
        .op_b             (op_b),
        .rd_regno         (rd_regno),
        .opcode           (opcode),
        .alu_result       (alu_result),
        .store_data       (store_data),
        .next_pc          (next_pc),
        .rd_out           (rd_out),
        .opcode_out       (opcode_out),
        .update_rd_out    (update_rd_out),
        .branch_taken_out (branch_taken_out),
        .mm_load_out      (mm_load_out)
    );

endmodule

`default_nettype wire

/* verification/execute_stage_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the RV64I execute stage
// Reads vectors from the test data file, drives
// the DUT and checks the latched outputs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_consts.svh"

module execute_stage_tb;
    import rv_exec_pkg::*;

    localparam int MAX_VECTORS  = 256;
    localparam int FIELDS       = 27;
    localparam int RESET_CYCLES = 16;

    logic                clk;
    logic                reset;
    logic                in_enable;
    logic                flush;
    opcode_t             opcode;
    logic [`XLEN-1:0]    pc;
    logic [`XLEN-1:0]    imm;
    logic [`XLEN-1:0]    rs1_value;
    logic [`XLEN-1:0]    rs2_value;
    logic [`REGNO_W-1:0] rs1_regno;
    logic [`REGNO_W-1:0] rs2_regno;
    logic [`REGNO_W-1:0] rd_regno;
    logic [`REGNO_W-1:0] alu_rd_regno;
    logic [`XLEN-1:0]    alu_result_fwd;
    logic                alu_is_load;
    logic [`REGNO_W-1:0] mm_rd_regno;
    logic [`XLEN-1:0]    mm_alu_result;
    logic [`XLEN-1:0]    mm_data;
    logic                mm_is_load;
    logic [`REGNO_W-1:0] wb_rd_regno;
    logic [`XLEN-1:0]    wb_data;
    logic                ready;
    logic [`XLEN-1:0]    alu_result;
    logic [`XLEN-1:0]    store_data;
    logic [`XLEN-1:0]    next_pc;
    logic [`REGNO_W-1:0] rd_out;
    opcode_t             opcode_out;
    logic                update_rd_out;
    logic                branch_taken_out;
    logic                mm_load_out;

    // One row per vector with inputs in fields 0 to 17 and expected values after them
    logic [63:0] vectors [MAX_VECTORS][FIELDS];
    int          num_vectors;
    int          cycle_count;
    int          cycle_limit;
    int          check_count;
    int          error_count;

    execute_stage i_dut
    (
        .clk              (clk),
        .reset            (reset),
        .in_enable        (in_enable),
        .flush            (flush),
        .opcode           (opcode),
        .pc               (pc),
        .imm              (imm),
        .rs1_value        (rs1_value),
        .rs2_value        (rs2_value),
        .rs1_regno        (rs1_regno),
        .rs2_regno        (rs2_regno),
        .rd_regno         (rd_regno),
        .alu_rd_regno     (alu_rd_regno),
        .alu_result_fwd   (alu_result_fwd),
        .alu_is_load      (alu_is_load),
        .mm_rd_regno      (mm_rd_regno),
        .mm_alu_result    (mm_alu_result),
        .mm_data          (mm_data),
        .mm_is_load       (mm_is_load),
        .wb_rd_regno      (wb_rd_regno),
        .wb_data          (wb_data),
        .ready            (ready),
        .alu_result       (alu_result),
        .store_data       (store_data),
        .next_pc          (next_pc),
        .rd_out           (rd_out),
        .opcode_out       (opcode_out),
        .update_rd_out    (update_rd_out),
        .branch_taken_out (branch_taken_out),
        .mm_load_out      (mm_load_out)
    );

    always #10 clk = ~clk;

    task finish_run();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    endtask

    initial
    begin
        while (cycle_limit == 0 || cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        error_count++;
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        finish_run();
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        assert (actual === expected)
        else
        begin
            error_count++;
            $display("Error at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic read_vectors();
        int                fd;
        int                got;
        logic              done;
        logic [8*256-1:0]  header;
        logic [63:0]       row [FIELDS];
        fd = $fopen("verification/execute_testdata.txt", "r");
        if (fd == 0)
        begin
            error_count++;
            $display("Could not open the test data file");
        end
        else
        begin
            // Two column description lines open the file
            got = $fgets(header, fd);
            got = $fgets(header, fd);
            done = 1'b0;
            while (!done && num_vectors < MAX_VECTORS)
            begin
                got = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              row[0], row[1], row[2], row[3], row[4], row[5],
                              row[6], row[7], row[8], row[9], row[10], row[11],
                              row[12], row[13], row[14], row[15], row[16], row[17]);
                if (got != 18)
                    done = 1'b1;
                else
                begin
                    got = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                                  row[18], row[19], row[20], row[21], row[22],
                                  row[23], row[24], row[25], row[26]);
                    if (got != 9)
                    begin
                        error_count++;
                        $display("Test data vector %0d is incomplete", num_vectors + 1);
                        done = 1'b1;
                    end
                    else
                    begin
                        for (int k = 0; k < FIELDS; k++)
                            vectors[num_vectors][k] = row[k];
                        num_vectors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_vector(input int n);
        int stall_cycles;
        stall_cycles = 0;
        @(posedge clk);
        in_enable      <= 1'b1;
        opcode         <= opcode_t'(vectors[n][0][5:0]);
        flush          <= vectors[n][1][0];
        pc             <= vectors[n][2];
        imm            <= vectors[n][3];
        rs1_value      <= vectors[n][4];
        rs2_value      <= vectors[n][5];
        rs1_regno      <= vectors[n][6][`REGNO_W-1:0];
        rs2_regno      <= vectors[n][7][`REGNO_W-1:0];
        rd_regno       <= vectors[n][8][`REGNO_W-1:0];
        alu_rd_regno   <= vectors[n][9][`REGNO_W-1:0];
        alu_result_fwd <= vectors[n][10];
        alu_is_load    <= vectors[n][11][0];
        mm_rd_regno    <= vectors[n][12][`REGNO_W-1:0];
        mm_alu_result  <= vectors[n][13];
        mm_data        <= vectors[n][14];
        mm_is_load     <= vectors[n][15][0];
        wb_rd_regno    <= vectors[n][16][`REGNO_W-1:0];
        wb_data        <= vectors[n][17];
        @(negedge clk);
        check_value("ready", ready, vectors[n][18]);
        // Hold the vector until the stage takes it
        while (!ready)
        begin
            @(posedge clk);
            @(negedge clk);
            stall_cycles++;
        end
        // A load-use hazard costs exactly one refused cycle
        check_count++;
        assert (stall_cycles == (vectors[n][18][0] ? 0 : 1))
        else
        begin
            error_count++;
            $display("Vector %0d was refused for %0d cycles", n + 1, stall_cycles);
        end
        @(posedge clk);
        in_enable <= 1'b0;
        flush     <= 1'b0;
        @(negedge clk);
        check_value("alu_result", alu_result, vectors[n][19]);
        check_value("store_data", store_data, vectors[n][20]);
        check_value("next_pc", next_pc, vectors[n][21]);
        check_value("rd_out", rd_out, vectors[n][22]);
        check_value("opcode_out", opcode_out, vectors[n][23]);
        check_value("update_rd_out", update_rd_out, vectors[n][24]);
        check_value("branch_taken_out", branch_taken_out, vectors[n][25]);
        check_value("mm_load_out", mm_load_out, vectors[n][26]);
    endtask

    initial
    begin
        clk            = 1'b0;
        reset          = 1'b1;
        in_enable      = 1'b0;
        flush          = 1'b0;
        opcode         = op_nop;
        pc             = '0;
        imm            = '0;
        rs1_value      = '0;
        rs2_value      = '0;
        rs1_regno      = '0;
        rs2_regno      = '0;
        rd_regno       = '0;
        alu_rd_regno   = '0;
        alu_result_fwd = '0;
        alu_is_load    = 1'b0;
        mm_rd_regno    = '0;
        mm_alu_result  = '0;
        mm_data        = '0;
        mm_is_load     = 1'b0;
        wb_rd_regno    = '0;
        wb_data        = '0;
        cycle_count    = 0;
        cycle_limit    = 0;
        check_count    = 0;
        error_count    = 0;
        num_vectors    = 0;

        read_vectors();
        if (num_vectors == 0)
        begin
            error_count++;
            $display("No test vectors were read");
        end
        cycle_limit = RESET_CYCLES + 4 * num_vectors + 10;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("ready", ready, 1);
        check_value("update_rd_out", update_rd_out, 0);
        check_value("branch_taken_out", branch_taken_out, 0);
        check_value("mm_load_out", mm_load_out, 0);
        check_value("alu_result", alu_result, 0);
        check_value("store_data", store_data, 0);
        check_value("next_pc", next_pc, 0);
        check_value("rd_out", rd_out, 0);
        check_value("opcode_out", opcode_out, op_nop);

        for (int n = 0; n < num_vectors; n++)
            apply_vector(n);
        finish_run();
    end

endmodule

`default_nettype wire

/* verification/execute_testdata.txt */
# in: opcode flush pc imm rs1_value rs2_value rs1_regno rs2_regno rd_regno alu_rd_regno alu_result_fwd alu_is_load mm_rd_regno mm_alu_result mm_data mm_is_load wb_rd_regno wb_data
# expected, all hex: ready alu_result store_data next_pc rd_out opcode_out update_rd_out branch_taken_out mm_load_out
1e 0 1000 0 7fffffffffffffff 1 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 8000000000000000 1 1004 05 1e 1 0 0
1f 0 1000 0 5 8 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 fffffffffffffffd 8 1004 05 1f 1 0 0
21 0 1000 0 ffffffffffffffff 1 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 1 1 1004 05 21 1 0 0
22 0 1000 0 ffffffffffffffff 1 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 1 1004 05 22 1 0 0
23 0 1000 0 ff00 ff0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 f0f0 ff0 1004 05 23 1 0 0
26 0 1000 0 ff00 ff0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 fff0 ff0 1004 05 26 1 0 0
27 0 1000 0 ff00 ff0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 f00 ff0 1004 05 27 1 0 0
20 0 1000 0 1 43 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 8 43 1004 05 20 1 0 0
24 0 1000 0 8000000000000000 3f 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 1 3f 1004 05 24 1 0 0
25 0 1000 0 8000000000000000 4 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 f800000000000000 4 1004 05 25 1 0 0
15 0 1000 fffffffffffffff0 10 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 0 1004 05 15 1 0 0
16 0 1000 ffffffffffffffff fffffffffffffffe 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 1 0 1004 05 16 1 0 0
17 0 1000 ffffffffffffffff 5 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 1 0 1004 05 17 1 0 0
18 0 1000 ffffffffffffffff f0 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 ffffffffffffff0f 0 1004 05 18 1 0 0
19 0 1000 f f0 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 ff 0 1004 05 19 1 0 0
1a 0 1000 3c f0 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 30 0 1004 05 1a 1 0 0
1b 0 1000 3c 3 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 3000000000000000 0 1004 05 1b 1 0 0
1c 0 1000 3c f000000000000000 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 f 0 1004 05 1c 1 0 0
1d 0 1000 3c f000000000000000 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 ffffffffffffffff 0 1004 05 1d 1 0 0
14 0 1000 ffffffff80000000 0 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 ffffffff80000000 0 1004 05 14 1 0 0
28 0 1000 1 7fffffff 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 ffffffff80000000 0 1004 05 28 1 0 0
29 0 1000 1f 1 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 ffffffff80000000 0 1004 05 29 1 0 0
2a 0 1000 1f ffffffff80000000 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 1 0 1004 05 2a 1 0 0
2b 0 1000 4 80000000 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 fffffffff8000000 0 1004 05 2b 1 0 0
2c 0 1000 0 7fffffff 1 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 ffffffff80000000 1 1004 05 2c 1 0 0
2d 0 1000 0 0 1 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 ffffffffffffffff 1 1004 05 2d 1 0 0
2e 0 1000 0 1 3f 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 ffffffff80000000 3f 1004 05 2e 1 0 0
2f 0 1000 0 80000000 4 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 8000000 4 1004 05 2f 1 0 0
30 0 1000 0 80000000 20 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 ffffffff80000000 20 1004 05 30 1 0 0
1e 0 1000 0 1 0 03 02 05 03 aaa 0 03 bbb ccc 0 1d 0 1 aaa 0 1004 05 1e 1 0 0
1e 0 1000 0 1 0 03 02 05 1f aaa 0 03 bbb ccc 0 1d 0 1 bbb 0 1004 05 1e 1 0 0
1e 0 1000 0 1 0 03 02 05 1f aaa 0 03 bbb ccc 1 1d 0 1 ccc 0 1004 05 1e 1 0 0
1e 0 1000 0 1 0 03 02 05 1f aaa 0 1e bbb ccc 0 03 ddd 1 ddd 0 1004 05 1e 1 0 0
1e 0 1000 0 1 0 01 04 05 1f aaa 0 1e bbb ccc 0 04 eee 1 eef eee 1004 05 1e 1 0 0
04 0 1000 8 2000 1 01 04 05 04 999 1 1e 0 777 0 1d 0 0 2008 777 1004 05 04 0 0 0
0c 0 1000 40 5 5 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 5 1040 05 0c 0 1 0
0c 0 1000 40 5 6 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 6 1004 05 0c 0 0 0
0d 0 1000 40 5 6 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 6 1040 05 0d 0 1 0
0d 0 1000 40 5 5 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 5 1004 05 0d 0 0 0
0e 0 1000 40 8000000000000000 7fffffffffffffff 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 7fffffffffffffff 1040 05 0e 0 1 0
0e 0 1000 40 7fffffffffffffff 8000000000000000 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 8000000000000000 1004 05 0e 0 0 0
0f 0 1000 40 7fffffffffffffff 8000000000000000 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 8000000000000000 1040 05 0f 0 1 0
0f 0 1000 40 ffffffffffffffff 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 0 1004 05 0f 0 0 0
10 0 1000 40 7fffffffffffffff 8000000000000000 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 8000000000000000 1040 05 10 0 1 0
10 0 1000 40 8000000000000000 7fffffffffffffff 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 7fffffffffffffff 1004 05 10 0 0 0
11 0 1000 40 ffffffffffffffff 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 0 1040 05 11 0 1 0
11 0 1000 40 0 1 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 1 1004 05 11 0 0 0
12 0 1000 100 0 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 1004 0 1100 05 12 1 1 0
13 0 1000 10 2001 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 1004 0 2010 05 13 1 1 0
08 0 1000 8 3000 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 3008 0 1004 05 08 0 0 1
09 0 1000 fffffffffffffffc 3000 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 2ffc 0 1004 05 09 0 0 1
03 0 1000 8 3000 1234 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 3008 1234 1004 05 03 0 0 0
00 0 1000 0 5 0 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 0 1004 05 00 0 0 0
1e 1 1000 0 5 6 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 0 0 0 00 00 0 0 0
1e 0 1000 0 2 3 01 02 05 1f 0 0 1e 0 0 0 1d 0 1 5 3 1004 05 1e 1 0 0

/* build.f */
+incdir+design
design/rv_exec_pkg.sv
design/operand_forward.sv
design/load_use_fsm.sv
design/int_alu.sv
design/branch_resolve.sv
design/ex_mm_latch.sv
design/execute_stage.sv
verification/execute_stage_tb.sv
